/* hdl/lsu_pkg.sv */
/*
  shared types for the reduced RV32 load/store unit
  physical addresses only, no translation
  imm is the raw 12-bit I/S immediate and is sign-extended in the AGU
*/
`default_nettype none

package lsu_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int unsigned XLEN          = 32;
    localparam int unsigned TRANS_ID_BITS = 3;
    localparam int unsigned BE_BITS       = 4;
    localparam int unsigned IMM_BITS      = 12;

    // loads first, then stores
    typedef enum logic [2:0] {
        LB, LBU, LH, LHU, LW, SB, SH, SW
    } lsu_op_e;

    // riscv mcause encodings
    typedef enum logic [3:0] {
        LD_ADDR_MISALIGNED = 4'd4,
        LD_ACCESS_FAULT    = 4'd5,
        ST_ADDR_MISALIGNED = 4'd6,
        ST_ACCESS_FAULT    = 4'd7
    } exc_cause_e;

    // controller state, same for both units
    typedef enum logic [1:0] {
        U_IDLE, U_ACCESS, U_RESPOND
    } unit_state_e;

    // ----------------------------------------
    // request and result words
    // ----------------------------------------
    typedef struct packed {
        lsu_op_e                  op;
        logic [XLEN-1:0]          operand_a;
        logic [XLEN-1:0]          operand_b;
        logic [IMM_BITS-1:0]      imm;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } lsu_issue_t;

    typedef struct packed {
        lsu_op_e                  op;
        logic                     is_store;
        logic [XLEN-1:0]          vaddr;
        logic [XLEN-1:0]          wdata;
        logic [BE_BITS-1:0]       be;
        logic                     misaligned;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } lsu_ctrl_t;

    typedef struct packed {
        logic            valid;
        exc_cause_e      cause;
        logic [XLEN-1:0] tval;
    } exception_t;

    typedef struct packed {
        logic                     valid;
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [XLEN-1:0]          data;
        exception_t               ex;
    } load_result_t;

    typedef struct packed {
        logic                     valid;
        logic [TRANS_ID_BITS-1:0] trans_id;
        exception_t               ex;
    } store_result_t;

    // ----------------------------------------
    // apb
    // ----------------------------------------
    typedef struct packed {
        logic               psel;
        logic               penable;
        logic               pwrite;
        logic [XLEN-1:0]    paddr;
        logic [XLEN-1:0]    pwdata;
        logic [BE_BITS-1:0] pstrb;
    } apb_req_t;

    typedef struct packed {
        logic [XLEN-1:0] prdata;
        logic            pready;
        logic            pslverr;
    } apb_resp_t;

endpackage

`default_nettype wire

/* hdl/lsu_agu.sv */
/*
  address generation, purely combinational
  byte enables for a misaligned halfword at offset 3 lose the top byte,
  harmless since that request never reaches the bus
*/
`timescale 1ns/1ps
`default_nettype none

module lsu_agu import lsu_pkg::*; (
    input  lsu_issue_t issue_i,
    input  logic       issue_valid_i,
    output lsu_ctrl_t  ctrl_o,
    output logic       ctrl_valid_o
);

    logic [XLEN-1:0] imm_sext;
    logic [XLEN-1:0] vaddr;
    logic [1:0]      offset;

    // base + sign-extended immediate
    assign imm_sext = {{(XLEN-IMM_BITS){issue_i.imm[IMM_BITS-1]}}, issue_i.imm};
    assign vaddr    = issue_i.operand_a + imm_sext;
    assign offset   = vaddr[1:0];

    always_comb begin
        ctrl_o          = '0;
        ctrl_o.op       = issue_i.op;
        ctrl_o.vaddr    = vaddr;
        ctrl_o.trans_id = issue_i.trans_id;
        ctrl_o.is_store = (issue_i.op == SB) || (issue_i.op == SH) || (issue_i.op == SW);
        // store data moved up to its byte lane
        ctrl_o.wdata    = issue_i.operand_b << {offset, 3'b000};

        case (issue_i.op)
            // halfword, bit 0 must be clear
            LH, LHU, SH: begin
                ctrl_o.be         = 4'b0011 << offset;
                ctrl_o.misaligned = offset[0];
            end
            // word, bits 1:0 must be clear
            LW, SW: begin
                ctrl_o.be         = 4'b1111;
                ctrl_o.misaligned = |offset;
            end
            // byte, always aligned
            default: begin
                ctrl_o.be         = 4'b0001 << offset;
                ctrl_o.misaligned = 1'b0;
            end
        endcase
    end

    assign ctrl_valid_o = issue_valid_i;

endmodule

`default_nettype wire

/* hdl/lsu_bypass.sv */
/*
  two-entry request FIFO with pass-through when empty
  only accepts a request while empty, matching issue_ready
  at most one pop per cycle, the head is either a load or a store
*/
`timescale 1ns/1ps
`default_nettype none

module lsu_bypass import lsu_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  lsu_ctrl_t req_i,
    input  logic      req_valid_i,
    input  logic      pop_ld_i,
    input  logic      pop_st_i,
    output lsu_ctrl_t head_o,
    output logic      head_valid_o,
    output logic      ready_o
);

    lsu_ctrl_t  mem_q [2];
    logic [1:0] valid_q;
    logic       rd_ptr_q;
    logic       wr_ptr_q;
    logic [1:0] cnt_q;
    logic       empty;
    logic       push;
    logic       pop;

    assign empty   = (cnt_q == 2'd0);
    assign ready_o = empty;
    assign push    = req_valid_i & empty;
    assign pop     = pop_ld_i | pop_st_i;

    // empty -> incoming request is the head
    assign head_o       = empty ? req_i : mem_q[rd_ptr_q];
    assign head_valid_o = empty ? req_valid_i : valid_q[rd_ptr_q];

    // storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= req_i;
        end
    end

    // pointers and count
    // push and pop on the same slot leave it invalid, pop wins
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            rd_ptr_q <= 1'b0;
            wr_ptr_q <= 1'b0;
            cnt_q    <= '0;
        end else begin
            if (push) begin
                valid_q[wr_ptr_q] <= 1'b1;
                wr_ptr_q          <= ~wr_ptr_q;
            end
            if (pop) begin
                valid_q[rd_ptr_q] <= 1'b0;
                rd_ptr_q          <= ~rd_ptr_q;
            end
            cnt_q <= cnt_q + {1'b0, push} - {1'b0, pop};
        end
    end

endmodule

`default_nettype wire

/* hdl/load_unit.sv */
/*
  load unit with one APB read master
  one load at a time, takes the head only while the store unit is idle
  misaligned loads skip the bus and report in the next cycle
*/
`timescale 1ns/1ps
`default_nettype none

module load_unit import lsu_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  lsu_ctrl_t    head_i,
    input  logic         head_valid_i,
    input  logic         busy_i,
    output logic         pop_o,
    output logic         busy_o,
    output apb_req_t     apb_o,
    input  apb_resp_t    apb_i,
    output load_result_t result_o
);

    unit_state_e     state_q;
    logic            penable_q;
    lsu_ctrl_t       req_q;
    logic [XLEN-1:0] rdata_q;
    logic            err_q;
    logic            take;
    logic            done;
    logic [XLEN-1:0] lane;
    logic [XLEN-1:0] ld_data;

    assign take   = head_valid_i && !head_i.is_store && (state_q == U_IDLE) && !busy_i;
    assign done   = (state_q == U_ACCESS) && penable_q && apb_i.pready;
    assign pop_o  = take;
    assign busy_o = (state_q != U_IDLE);

    // ----------------------------------------
    // controller
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= U_IDLE;
            penable_q <= 1'b0;
        end else begin
            case (state_q)
                U_IDLE: begin
                    if (take) begin
                        state_q <= head_i.misaligned ? U_RESPOND : U_ACCESS;
                    end
                end
                // setup cycle, then access until pready
                U_ACCESS: begin
                    if (!penable_q) begin
                        penable_q <= 1'b1;
                    end else if (apb_i.pready) begin
                        penable_q <= 1'b0;
                        state_q   <= U_RESPOND;
                    end
                end
                default: state_q <= U_IDLE;
            endcase
        end
    end

    // request and read data
    always_ff @(posedge clk_i) begin
        if (take) begin
            req_q <= head_i;
        end
        if (done) begin
            rdata_q <= apb_i.prdata;
            err_q   <= apb_i.pslverr;
        end
    end

    // read only, word address
    always_comb begin
        apb_o         = '0;
        apb_o.psel    = (state_q == U_ACCESS);
        apb_o.penable = penable_q;
        apb_o.paddr   = {req_q.vaddr[XLEN-1:2], 2'b00};
    end

    // ----------------------------------------
    // lane extraction and extension
    // ----------------------------------------
    assign lane = rdata_q >> {req_q.vaddr[1:0], 3'b000};

    always_comb begin
        case (req_q.op)
            LB:      ld_data = {{(XLEN-8){lane[7]}}, lane[7:0]};
            LBU:     ld_data = {{(XLEN-8){1'b0}}, lane[7:0]};
            LH:      ld_data = {{(XLEN-16){lane[15]}}, lane[15:0]};
            LHU:     ld_data = {{(XLEN-16){1'b0}}, lane[15:0]};
            default: ld_data = rdata_q;
        endcase
    end

    // writeback, misaligned takes priority (no bus access happened)
    always_comb begin
        result_o          = '0;
        result_o.valid    = (state_q == U_RESPOND);
        result_o.trans_id = req_q.trans_id;
        if (req_q.misaligned) begin
            result_o.ex.valid = 1'b1;
            result_o.ex.cause = LD_ADDR_MISALIGNED;
            result_o.ex.tval  = req_q.vaddr;
        end else if (err_q) begin
            result_o.ex.valid = 1'b1;
            result_o.ex.cause = LD_ACCESS_FAULT;
            result_o.ex.tval  = req_q.vaddr;
        end else begin
            result_o.data = ld_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/store_unit.sv */
/*
  store unit with one APB write master
  no commit queue, the write goes out as soon as the store is taken
  misaligned stores skip the bus, memory stays unchanged
*/
`timescale 1ns/1ps
`default_nettype none

module store_unit import lsu_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  lsu_ctrl_t     head_i,
    input  logic          head_valid_i,
    input  logic          busy_i,
    output logic          pop_o,
    output logic          busy_o,
    output apb_req_t      apb_o,
    input  apb_resp_t     apb_i,
    output store_result_t result_o
);

    unit_state_e state_q;
    logic        penable_q;
    lsu_ctrl_t   req_q;
    logic        err_q;
    logic        take;
    logic        done;

    assign take   = head_valid_i && head_i.is_store && (state_q == U_IDLE) && !busy_i;
    assign done   = (state_q == U_ACCESS) && penable_q && apb_i.pready;
    assign pop_o  = take;
    assign busy_o = (state_q != U_IDLE);

    // ----------------------------------------
    // controller
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= U_IDLE;
            penable_q <= 1'b0;
        end else begin
            case (state_q)
                U_IDLE: begin
                    if (take) begin
                        state_q <= head_i.misaligned ? U_RESPOND : U_ACCESS;
                    end
                end
                U_ACCESS: begin
                    if (!penable_q) begin
                        penable_q <= 1'b1;
                    end else if (apb_i.pready) begin
                        penable_q <= 1'b0;
                        state_q   <= U_RESPOND;
                    end
                end
                default: state_q <= U_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            req_q <= head_i;
        end
        if (done) begin
            err_q <= apb_i.pslverr;
        end
    end

    // data already in its lane, strobes straight from the byte enables
    always_comb begin
        apb_o         = '0;
        apb_o.psel    = (state_q == U_ACCESS);
        apb_o.penable = penable_q;
        apb_o.pwrite  = 1'b1;
        apb_o.paddr   = {req_q.vaddr[XLEN-1:2], 2'b00};
        apb_o.pwdata  = req_q.wdata;
        apb_o.pstrb   = req_q.be;
    end

    // completion
    always_comb begin
        result_o          = '0;
        result_o.valid    = (state_q == U_RESPOND);
        result_o.trans_id = req_q.trans_id;
        if (req_q.misaligned) begin
            result_o.ex.valid = 1'b1;
            result_o.ex.cause = ST_ADDR_MISALIGNED;
            result_o.ex.tval  = req_q.vaddr;
        end else if (err_q) begin
            result_o.ex.valid = 1'b1;
            result_o.ex.cause = ST_ACCESS_FAULT;
            result_o.ex.tval  = req_q.vaddr;
        end
    end

endmodule

`default_nettype wire

/* hdl/lsu_top.sv */
/*
  load/store unit top, AGU -> FIFO -> load or store unit
  issue is accepted only while the FIFO is empty
  ordering: the head leaves only when both units are idle
*/
`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  logic          issue_valid_i,
    input  lsu_issue_t    issue_i,
    output logic          issue_ready_o,
    output apb_req_t      ld_apb_o,
    input  apb_resp_t     ld_apb_i,
    output apb_req_t      st_apb_o,
    input  apb_resp_t     st_apb_i,
    output load_result_t  load_o,
    output store_result_t store_o
);

    lsu_ctrl_t ctrl;
    logic      ctrl_valid;
    lsu_ctrl_t head;
    logic      head_valid;
    logic      pop_ld;
    logic      pop_st;
    logic      ld_busy;
    logic      st_busy;

    // ----------------------------------------
    // request path
    // ----------------------------------------
    lsu_agu u_agu (
        .issue_i       ( issue_i       ),
        .issue_valid_i ( issue_valid_i ),
        .ctrl_o        ( ctrl          ),
        .ctrl_valid_o  ( ctrl_valid    )
    );

    lsu_bypass u_bypass (
        .clk_i        ( clk_i         ),
        .rst_ni       ( rst_ni        ),
        .req_i        ( ctrl          ),
        .req_valid_i  ( ctrl_valid    ),
        .pop_ld_i     ( pop_ld        ),
        .pop_st_i     ( pop_st        ),
        .head_o       ( head          ),
        .head_valid_o ( head_valid    ),
        .ready_o      ( issue_ready_o )
    );

    // ----------------------------------------
    // units, each blocked by the other's busy
    // ----------------------------------------
    load_unit u_load_unit (
        .clk_i        ( clk_i      ),
        .rst_ni       ( rst_ni     ),
        .head_i       ( head       ),
        .head_valid_i ( head_valid ),
        .busy_i       ( st_busy    ),
        .pop_o        ( pop_ld     ),
        .busy_o       ( ld_busy    ),
        .apb_o        ( ld_apb_o   ),
        .apb_i        ( ld_apb_i   ),
        .result_o     ( load_o     )
    );

    store_unit u_store_unit (
        .clk_i        ( clk_i      ),
        .rst_ni       ( rst_ni     ),
        .head_i       ( head       ),
        .head_valid_i ( head_valid ),
        .busy_i       ( ld_busy    ),
        .pop_o        ( pop_st     ),
        .busy_o       ( st_busy    ),
        .apb_o        ( st_apb_o   ),
        .apb_i        ( st_apb_i   ),
        .result_o     ( store_o    )
    );

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
/*
  clock and reset source for the LSU testbench
  10 ns period, reset low for the first 10 rising edges
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // release just after an edge
    initial begin
        rst_no = 1'b0;
        repeat (10) @(posedge clk_o);
        #1 rst_no = 1'b1;
    end

endmodule

`default_nettype wire

/* verif/apb_mem_model.sv */
/*
  APB slave memory, one instance per LSU port
  storage is the array mem in tb_lsu_top, 256 words, paddr[9:2] indexes it
  0 to 2 wait states per transfer, pslverr for paddr[31:28] == 4'hF
*/
`timescale 1ns/1ps
`default_nettype none

module apb_mem_model import lsu_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  apb_req_t  apb_i,
    output apb_resp_t apb_o
);

    logic [1:0]      wait_q;
    logic [7:0]      idx;
    logic            err_region;
    logic            ready;
    logic [XLEN-1:0] merged;

    assign idx        = apb_i.paddr[9:2];
    assign err_region = (apb_i.paddr[XLEN-1:XLEN-4] == 4'hF);
    assign ready      = apb_i.psel && apb_i.penable && (wait_q == 2'd0);

    // wait count drawn in setup, counted down in access
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wait_q <= '0;
        end else if (apb_i.psel && !apb_i.penable) begin
            wait_q <= 2'($urandom_range(2, 0));
        end else if (apb_i.penable && (wait_q != 2'd0)) begin
            wait_q <= wait_q - 2'd1;
        end
    end

    always_comb begin
        apb_o         = '0;
        apb_o.prdata  = tb_lsu_top.mem[idx];
        apb_o.pready  = ready;
        apb_o.pslverr = ready && err_region;
    end

    // strobed bytes over the old word
    always_comb begin
        merged = tb_lsu_top.mem[idx];
        for (int b = 0; b < BE_BITS; b++) begin
            if (apb_i.pstrb[b]) begin
                merged[8*b +: 8] = apb_i.pwdata[8*b +: 8];
            end
        end
    end

    // faulting writes leave memory alone
    always @(posedge clk_i) begin
        if (ready && apb_i.pwrite && !err_region) begin
            tb_lsu_top.mem[idx] <= merged;
        end
    end

endmodule

`default_nettype wire

/* verif/lsu_scoreboard.sv */
/*
  result checker for both LSU writeback channels
  expected values arrive through expect_result before the issue is accepted
  one entry per trans_id, each must be matched exactly once
*/
`timescale 1ns/1ps
`default_nettype none

module lsu_scoreboard import lsu_pkg::*; (
    input  logic          clk_i,
    input  load_result_t  load_i,
    input  store_result_t store_i,
    output int            done_cnt_o,
    output int            err_cnt_o
);

    string           exp_name  [2**TRANS_ID_BITS];
    logic            pending   [2**TRANS_ID_BITS];
    logic            exp_store [2**TRANS_ID_BITS];
    logic [XLEN-1:0] exp_data  [2**TRANS_ID_BITS];
    logic            exp_ex    [2**TRANS_ID_BITS];
    logic [3:0]      exp_cause [2**TRANS_ID_BITS];
    logic [XLEN-1:0] exp_tval  [2**TRANS_ID_BITS];
    int              done_cnt = 0;
    int              pass_cnt = 0;
    int              err_cnt  = 0;

    assign done_cnt_o = done_cnt;
    assign err_cnt_o  = err_cnt;

    initial begin
        foreach (pending[i]) begin
            pending[i] = 1'b0;
        end
    end

    task automatic expect_result(input string name, input logic is_store,
                                 input logic [TRANS_ID_BITS-1:0] tid,
                                 input logic [XLEN-1:0] data, input logic ex_valid,
                                 input logic [3:0] cause, input logic [XLEN-1:0] tval);
        if (pending[tid]) begin
            $display("ERROR: trans_id %0d issued again while still outstanding", tid);
            err_cnt++;
        end
        pending[tid]   = 1'b1;
        exp_name[tid]  = name;
        exp_store[tid] = is_store;
        exp_data[tid]  = data;
        exp_ex[tid]    = ex_valid;
        exp_cause[tid] = cause;
        exp_tval[tid]  = tval;
    endtask

    task automatic check_result(input logic is_store, input logic [TRANS_ID_BITS-1:0] tid,
                                input logic [XLEN-1:0] data, input exception_t ex);
        logic ok;
        if (!pending[tid] || (exp_store[tid] != is_store)) begin
            $display("ERROR: %s result with trans_id %0d matches no outstanding request",
                     is_store ? "store" : "load", tid);
            err_cnt++;
            return;
        end
        pending[tid] = 1'b0;
        done_cnt++;
        if (exp_ex[tid]) begin
            ok = ex.valid && (ex.cause == exp_cause[tid]) && (ex.tval == exp_tval[tid]);
            if (!ok) begin
                $display("MISMATCH %s: expected cause %0d tval %h, actual ex %0b cause %0d tval %h",
                         exp_name[tid], exp_cause[tid], exp_tval[tid], ex.valid, ex.cause, ex.tval);
            end
        end else if (is_store) begin
            ok = !ex.valid;
            if (!ok) begin
                $display("MISMATCH %s: expected no exception, actual cause %0d tval %h",
                         exp_name[tid], ex.cause, ex.tval);
            end
        end else begin
            ok = !ex.valid && (data == exp_data[tid]);
            if (!ok) begin
                $display("MISMATCH %s: expected data %h, actual data %h (ex %0b cause %0d)",
                         exp_name[tid], exp_data[tid], data, ex.valid, ex.cause);
            end
        end
        if (ok) begin
            pass_cnt++;
            $display("PASS %s", exp_name[tid]);
        end else begin
            err_cnt++;
        end
    endtask

    // results are stable at the rising edge
    always @(posedge clk_i) begin
        if (load_i.valid === 1'b1) begin
            check_result(1'b0, load_i.trans_id, load_i.data, load_i.ex);
        end
        if (store_i.valid === 1'b1) begin
            check_result(1'b1, store_i.trans_id, '0, store_i.ex);
        end
    end

    task automatic print_counts();
        $display("tests %0d, passed %0d, errors %0d", done_cnt, pass_cnt, err_cnt);
    endtask

endmodule

`default_nettype wire

/* verif/lsu_checker.sv */
/*
  APB protocol and writeback assertions, bound into lsu_top
  fail_cnt holds the number of failed assertions
*/
`timescale 1ns/1ps
`default_nettype none

module lsu_checker import lsu_pkg::*; (
    input logic          clk_i,
    input logic          rst_ni,
    input apb_req_t      ld_req_i,
    input apb_req_t      st_req_i,
    input load_result_t  load_i,
    input store_result_t store_i
);

    int fail_cnt = 0;

    // ----------------------------------------
    // access phase holds the request
    // ----------------------------------------
    ld_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ld_req_i.penable |-> $stable({ld_req_i.paddr, ld_req_i.pwrite,
                                      ld_req_i.pwdata, ld_req_i.pstrb}))
    else begin
        $error("load port request changed during the access phase");
        fail_cnt++;
    end

    st_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        st_req_i.penable |-> $stable({st_req_i.paddr, st_req_i.pwrite,
                                      st_req_i.pwdata, st_req_i.pstrb}))
    else begin
        $error("store port request changed during the access phase");
        fail_cnt++;
    end

    // penable only after a setup cycle
    ld_setup: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(ld_req_i.penable) |-> $past(ld_req_i.psel && !ld_req_i.penable))
    else begin
        $error("load port penable rose without a setup phase");
        fail_cnt++;
    end

    st_setup: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(st_req_i.penable) |-> $past(st_req_i.psel && !st_req_i.penable))
    else begin
        $error("store port penable rose without a setup phase");
        fail_cnt++;
    end

    // one unit on the bus at a time
    one_psel: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(ld_req_i.psel && st_req_i.psel))
    else begin
        $error("both ports selected in the same cycle");
        fail_cnt++;
    end

    // ----------------------------------------
    // single-cycle writeback pulses
    // ----------------------------------------
    ld_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        load_i.valid |=> !load_i.valid)
    else begin
        $error("load result valid held for more than one cycle");
        fail_cnt++;
    end

    st_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        store_i.valid |=> !store_i.valid)
    else begin
        $error("store result valid held for more than one cycle");
        fail_cnt++;
    end

endmodule

bind lsu_top lsu_checker u_checker (
    .clk_i    ( clk_i    ),
    .rst_ni   ( rst_ni   ),
    .ld_req_i ( ld_apb_o ),
    .st_req_i ( st_apb_o ),
    .load_i   ( load_o   ),
    .store_i  ( store_o  )
);

`default_nettype wire

/* verif/tb_lsu_top.sv */
/*
  testbench top for lsu_top
  rows issue in order, each waits for issue_ready, inputs change 1 ns after the edge
  memory word k starts as 32'hA5000000 + k, addresses alias every 1 KiB
  run is capped at 40 cycles per row plus 100
*/
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top import lsu_pkg::*; ();

    typedef struct {
        string               name;
        lsu_op_e             op;
        logic [XLEN-1:0]     base;
        logic [IMM_BITS-1:0] imm;
        logic [XLEN-1:0]     wdata;
        logic [XLEN-1:0]     exp_data;
        logic                exp_ex;
        logic [3:0]          exp_cause;
    } row_t;

    logic            clk;
    logic            rst_n;
    logic            issue_valid;
    lsu_issue_t      issue;
    logic            issue_ready;
    apb_req_t        ld_req;
    apb_resp_t       ld_resp;
    apb_req_t        st_req;
    apb_resp_t       st_resp;
    load_result_t    load_res;
    store_result_t   store_res;
    logic [XLEN-1:0] mem [256];
    row_t            rows [$];
    int unsigned     cycle_cnt    = 0;
    int unsigned     limit_cycles = 0;
    int              done_cnt;
    int              err_cnt;

    tb_clock_gen u_clock_gen (
        .clk_o  ( clk   ),
        .rst_no ( rst_n )
    );

    lsu_top u_lsu_top (
        .clk_i         ( clk         ),
        .rst_ni        ( rst_n       ),
        .issue_valid_i ( issue_valid ),
        .issue_i       ( issue       ),
        .issue_ready_o ( issue_ready ),
        .ld_apb_o      ( ld_req      ),
        .ld_apb_i      ( ld_resp     ),
        .st_apb_o      ( st_req      ),
        .st_apb_i      ( st_resp     ),
        .load_o        ( load_res    ),
        .store_o       ( store_res   )
    );

    apb_mem_model u_ld_mem (
        .clk_i  ( clk     ),
        .rst_ni ( rst_n   ),
        .apb_i  ( ld_req  ),
        .apb_o  ( ld_resp )
    );

    apb_mem_model u_st_mem (
        .clk_i  ( clk     ),
        .rst_ni ( rst_n   ),
        .apb_i  ( st_req  ),
        .apb_o  ( st_resp )
    );

    lsu_scoreboard u_scoreboard (
        .clk_i      ( clk       ),
        .load_i     ( load_res  ),
        .store_i    ( store_res ),
        .done_cnt_o ( done_cnt  ),
        .err_cnt_o  ( err_cnt   )
    );

    function automatic logic is_store_op(input lsu_op_e op);
        return op inside {SB, SH, SW};
    endfunction

    task automatic add_row(input string name, input lsu_op_e op, input logic [XLEN-1:0] base,
                           input logic [IMM_BITS-1:0] imm, input logic [XLEN-1:0] wdata,
                           input logic [XLEN-1:0] exp_data, input logic exp_ex,
                           input logic [3:0] exp_cause);
        row_t r;
        r.name      = name;
        r.op        = op;
        r.base      = base;
        r.imm       = imm;
        r.wdata     = wdata;
        r.exp_data  = exp_data;
        r.exp_ex    = exp_ex;
        r.exp_cause = exp_cause;
        rows.push_back(r);
    endtask

    // ----------------------------------------
    // stimulus table
    // ----------------------------------------
    task automatic build_rows();
        // aligned loads of word 0x90 = A5000090
        add_row("lw_aligned",  LW,  32'h0000_0240, 12'h000, 32'h0, 32'hA500_0090, 1'b0, 4'd0);
        add_row("lb_lane0",    LB,  32'h0000_0240, 12'h000, 32'h0, 32'hFFFF_FF90, 1'b0, 4'd0);
        add_row("lbu_neg_imm", LBU, 32'h0000_0250, 12'hFF0, 32'h0, 32'h0000_0090, 1'b0, 4'd0);
        add_row("lb_lane3",    LB,  32'h0000_0240, 12'h003, 32'h0, 32'hFFFF_FFA5, 1'b0, 4'd0);
        add_row("lbu_lane3",   LBU, 32'h0000_0243, 12'h000, 32'h0, 32'h0000_00A5, 1'b0, 4'd0);
        add_row("lh_upper",    LH,  32'h0000_0242, 12'h000, 32'h0, 32'hFFFF_A500, 1'b0, 4'd0);
        add_row("lhu_upper",   LHU, 32'h0000_0242, 12'h000, 32'h0, 32'h0000_A500, 1'b0, 4'd0);
        add_row("lh_lower",    LH,  32'h0000_0240, 12'h000, 32'h0, 32'h0000_0090, 1'b0, 4'd0);
        // store then load on word 0x91
        add_row("sw_full",     SW,  32'h0000_0244, 12'h000, 32'h1234_5678, 32'h0, 1'b0, 4'd0);
        add_row("lw_after_sw", LW,  32'h0000_0244, 12'h000, 32'h0, 32'h1234_5678, 1'b0, 4'd0);
        add_row("sb_lane2",    SB,  32'h0000_0244, 12'h002, 32'h0000_00EE, 32'h0, 1'b0, 4'd0);
        add_row("sh_lower",    SH,  32'h0000_0244, 12'h000, 32'h0000_CAFE, 32'h0, 1'b0, 4'd0);
        add_row("lw_merged",   LW,  32'h0000_0244, 12'h000, 32'h0, 32'h12EE_CAFE, 1'b0, 4'd0);
        add_row("lb_merged",   LB,  32'h0000_0246, 12'h000, 32'h0, 32'hFFFF_FFEE, 1'b0, 4'd0);
        // misaligned accesses leave word 0x92 intact
        add_row("lh_misalign", LH,  32'h0000_0248, 12'h001, 32'h0, 32'h0, 1'b1, 4'd4);
        add_row("lw_misalign", LW,  32'h0000_024A, 12'h000, 32'h0, 32'h0, 1'b1, 4'd4);
        add_row("sh_misalign", SH,  32'h0000_024B, 12'h000, 32'hFFFF_FFFF, 32'h0, 1'b1, 4'd6);
        add_row("sw_misalign", SW,  32'h0000_0248, 12'h001, 32'h0, 32'h0, 1'b1, 4'd6);
        add_row("lw_intact",   LW,  32'h0000_0248, 12'h000, 32'h0, 32'hA500_0092, 1'b0, 4'd0);
        // error region
        add_row("lw_fault",    LW,  32'hF000_0000, 12'h010, 32'h0, 32'h0, 1'b1, 4'd5);
        add_row("sb_fault",    SB,  32'hF000_0100, 12'hFFF, 32'h0000_0055, 32'h0, 1'b1, 4'd7);
        // mixed burst on word 0x93
        add_row("sw_burst",    SW,  32'h0000_024C, 12'h000, 32'h0BAD_F00D, 32'h0, 1'b0, 4'd0);
        add_row("lhu_burst",   LHU, 32'h0000_024E, 12'h000, 32'h0, 32'h0000_0BAD, 1'b0, 4'd0);
        add_row("sb_burst",    SB,  32'h0000_024C, 12'h000, 32'h0000_00AA, 32'h0, 1'b0, 4'd0);
        add_row("lw_burst",    LW,  32'h0000_024C, 12'h000, 32'h0, 32'h0BAD_F0AA, 1'b0, 4'd0);
        add_row("lh_neg_imm",  LH,  32'h0000_0300, 12'hF4E, 32'h0, 32'h0000_0BAD, 1'b0, 4'd0);
    endtask

    // ----------------------------------------
    // issue loop and verdict
    // ----------------------------------------
    initial begin
        row_t            r;
        logic [XLEN-1:0] addr;
        void'($urandom(32'h17d6));
        issue_valid = 1'b0;
        issue       = '0;
        for (int k = 0; k < 256; k++) begin
            mem[k] <= 32'hA500_0000 + k;
        end
        build_rows();
        limit_cycles = 40 * rows.size() + 100;

        wait (rst_n === 1'b1);
        @(posedge clk);
        #1;
        foreach (rows[i]) begin
            r    = rows[i];
            // expected tval is the base plus the signed immediate
            addr = r.base + XLEN'($signed(r.imm));
            issue_valid       = 1'b1;
            issue.op          = r.op;
            issue.operand_a   = r.base;
            issue.operand_b   = r.wdata;
            issue.imm         = r.imm;
            issue.trans_id    = TRANS_ID_BITS'(i);
            while (issue_ready !== 1'b1) begin
                @(posedge clk);
                #1;
            end
            // ready is high, so the next edge accepts
            u_scoreboard.expect_result(r.name, is_store_op(r.op), TRANS_ID_BITS'(i),
                                       r.exp_data, r.exp_ex, r.exp_cause, addr);
            @(posedge clk);
            #1;
        end
        issue_valid = 1'b0;

        while (done_cnt < rows.size()) begin
            @(posedge clk);
        end
        // catch stray results
        repeat (10) @(posedge clk);
        u_scoreboard.print_counts();
        if ((err_cnt == 0) && (u_lsu_top.u_checker.fail_cnt == 0)) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if ((limit_cycles != 0) && (cycle_cnt >= limit_cycles)) begin
            $display("ERROR: run did not finish within %0d cycles", limit_cycles);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* lsu_top.f */
hdl/lsu_pkg.sv
hdl/lsu_agu.sv
hdl/lsu_bypass.sv
hdl/load_unit.sv
hdl/store_unit.sv
hdl/lsu_top.sv
verif/tb_clock_gen.sv
verif/apb_mem_model.sv
verif/lsu_scoreboard.sv
verif/lsu_checker.sv
verif/tb_lsu_top.sv

/* run.sh */
#!/bin/sh
# build the LSU testbench with Verilator and run it
# exit status is 0 only when the pass message shows up in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_lsu_top -f lsu_top.f \
    && ./obj_dir/Vtb_lsu_top +verilator+error+limit+100 | tee /dev/stderr \
        | grep "Simulation completed successfully" > /dev/null \
    && echo "lsu_top: run passed" \
    || { echo "lsu_top: run failed"; exit 1; }
